// File: logic/remap_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared encodings for the packet remapper
// Both enums are two bits wide and must stay in sync with their users
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package remap_pkg;

    // Frame sequencer states
    typedef enum logic [1:0] {
        // Waiting for a sync pulse, input stream open
        SEQ_IDLE = 2'd0,
        // A word that is not the last one is on the output
        SEQ_SEND = 2'd1,
        // The final word of the frame is on the output
        SEQ_LAST = 2'd2
    } seq_state_t;

    // Slot counter opcodes
    typedef enum logic [1:0] {
        // Keep the current index
        CNT_HOLD  = 2'd0,
        // Go back to slot 0
        CNT_CLEAR = 2'd1,
        // Advance by one slot
        CNT_STEP  = 2'd2
    } cnt_cmd_t;

endpackage

// File: logic/skid_buffer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Two-entry input stage with a registered in_ready
// in_ready stays low during reset and rises one cycle after it
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module skid_buffer #(
    parameter int DATA_WIDTH = 32,
    parameter int USER_WIDTH = 8,
    parameter int DEST_WIDTH = 8
) (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  in_valid,
    output logic                  in_ready,
    input  logic [DATA_WIDTH-1:0] in_data,
    input  logic [USER_WIDTH-1:0] in_user,
    input  logic [DEST_WIDTH-1:0] in_dest,
    output logic                  buf_valid,
    input  logic                  buf_ready,
    output logic [DATA_WIDTH-1:0] buf_data,
    output logic [USER_WIDTH-1:0] buf_user,
    output logic [DEST_WIDTH-1:0] buf_dest
);

    logic                  skid_valid;
    logic [DATA_WIDTH-1:0] skid_data;
    logic [USER_WIDTH-1:0] skid_user;
    logic [DEST_WIDTH-1:0] skid_dest;
    logic                  in_fire;
    logic                  main_free;

    assign in_fire   = in_valid && in_ready;
    // The main entry can take a word when it is empty or drains this cycle
    assign main_free = !buf_valid || buf_ready;

    always_ff @(posedge clock) begin
        if (!reset) begin
            buf_valid  <= 1'b0;
            skid_valid <= 1'b0;
            in_ready   <= 1'b0;
        end else if (main_free) begin
            // A parked word always moves up before any new one
            buf_valid  <= skid_valid || in_fire;
            skid_valid <= 1'b0;
            in_ready   <= 1'b1;
        end else if (in_fire) begin
            // Downstream stalled while a word came in, so park it
            skid_valid <= 1'b1;
            in_ready   <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (main_free) begin
            if (skid_valid) begin
                buf_data <= skid_data;
                buf_user <= skid_user;
                buf_dest <= skid_dest;
            end else if (in_fire) begin
                buf_data <= in_data;
                buf_user <= in_user;
                buf_dest <= in_dest;
            end
        end else if (in_fire) begin
            skid_data <= in_data;
            skid_user <= in_user;
            skid_dest <= in_dest;
        end
    end

endmodule

// File: logic/slot_store.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Slot register file, one entry per frame position
// Destinations outside the window are silently dropped
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module slot_store #(
    parameter int DATA_WIDTH    = 32,
    parameter int USER_WIDTH    = 8,
    parameter int DEST_WIDTH    = 8,
    parameter int PACKET_LENGTH = 3,
    parameter int DEST_BASE     = 0,
    localparam int INDEX_WIDTH  = $clog2(PACKET_LENGTH)
) (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   wr_en,
    input  logic [DATA_WIDTH-1:0]  wr_data,
    input  logic [USER_WIDTH-1:0]  wr_user,
    input  logic [DEST_WIDTH-1:0]  wr_dest,
    input  logic [INDEX_WIDTH-1:0] rd_index,
    output logic [DATA_WIDTH-1:0]  rd_data,
    output logic [USER_WIDTH-1:0]  rd_user
);

    logic [DATA_WIDTH-1:0]  slot_data [PACKET_LENGTH];
    logic [USER_WIDTH-1:0]  slot_user [PACKET_LENGTH];
    logic [DEST_WIDTH:0]    offset;
    logic                   in_window;
    logic [INDEX_WIDTH-1:0] wr_index;

    // One extra bit so that destinations below the base wrap to a large offset
    assign offset    = {1'b0, wr_dest} - (DEST_WIDTH + 1)'(DEST_BASE);
    assign in_window = offset < (DEST_WIDTH + 1)'(PACKET_LENGTH);
    assign wr_index  = offset[INDEX_WIDTH-1:0];

    always_ff @(posedge clock) begin
        if (!reset) begin
            // Unwritten slots read back as zero
            for (int i = 0; i < PACKET_LENGTH; i++) begin
                slot_data[i] <= '0;
                slot_user[i] <= '0;
            end
        end else if (wr_en && in_window) begin
            slot_data[wr_index] <= wr_data;
            slot_user[wr_index] <= wr_user;
        end
    end

    assign rd_data = slot_data[rd_index];
    assign rd_user = slot_user[rd_index];

endmodule

// File: logic/slot_counter.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Slot index counter driven by an opcode
// Stepping past the last slot wraps to zero
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module slot_counter import remap_pkg::*; #(
    parameter int PACKET_LENGTH = 3,
    localparam int INDEX_WIDTH  = $clog2(PACKET_LENGTH)
) (
    input  logic                   clock,
    input  logic                   reset,
    input  cnt_cmd_t               cmd,
    output logic [INDEX_WIDTH-1:0] slot_index,
    output logic                   at_last
);

    localparam logic [INDEX_WIDTH-1:0] LAST_INDEX = INDEX_WIDTH'(PACKET_LENGTH - 1);

    assign at_last = (slot_index == LAST_INDEX);

    always_ff @(posedge clock) begin
        if (!reset) begin
            slot_index <= '0;
        end else begin
            case (cmd)
                CNT_CLEAR: begin
                    slot_index <= '0;
                end
                CNT_STEP: begin
                    // Keeps the index inside the slot range
                    if (at_last) begin
                        slot_index <= '0;
                    end else begin
                        slot_index <= slot_index + 1'b1;
                    end
                end
                default: begin
                    slot_index <= slot_index;
                end
            endcase
        end
    end

endmodule

// File: logic/frame_sequencer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Frame FSM and output word register
// Input is only accepted in SEQ_IDLE, sync during a frame is ignored
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module frame_sequencer import remap_pkg::*; #(
    parameter int DATA_WIDTH    = 32,
    parameter int USER_WIDTH    = 8,
    parameter int DEST_WIDTH    = 8,
    parameter int PACKET_LENGTH = 3,
    localparam int INDEX_WIDTH  = $clog2(PACKET_LENGTH)
) (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   sync,
    output logic                   buf_ready,
    output cnt_cmd_t               cnt_cmd,
    input  logic [INDEX_WIDTH-1:0] slot_index,
    input  logic                   at_last,
    input  logic [DATA_WIDTH-1:0]  rd_data,
    input  logic [USER_WIDTH-1:0]  rd_user,
    output logic                   out_valid,
    input  logic                   out_ready,
    output logic [DATA_WIDTH-1:0]  out_data,
    output logic [USER_WIDTH-1:0]  out_user,
    output logic [DEST_WIDTH-1:0]  out_dest,
    output logic                   out_last
);

    seq_state_t state;
    logic       out_fire;
    logic       load;

    assign out_fire  = out_valid && out_ready;
    // Freeze the slots while a frame is on the way out
    assign buf_ready = (state == SEQ_IDLE);

    always_comb begin
        cnt_cmd = CNT_HOLD;
        load    = 1'b0;
        case (state)
            SEQ_IDLE: begin
                if (sync) begin
                    load    = 1'b1;
                    cnt_cmd = CNT_STEP;
                end
            end
            SEQ_SEND: begin
                if (out_fire) begin
                    load = 1'b1;
                    // The counter already points at the last slot here
                    cnt_cmd = at_last ? CNT_HOLD : CNT_STEP;
                end
            end
            SEQ_LAST: begin
                if (out_fire) begin
                    cnt_cmd = CNT_CLEAR;
                end
            end
            default: begin
                cnt_cmd = CNT_CLEAR;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            state     <= SEQ_IDLE;
            out_valid <= 1'b0;
            out_last  <= 1'b0;
        end else begin
            case (state)
                SEQ_IDLE: begin
                    if (sync) begin
                        state     <= SEQ_SEND;
                        out_valid <= 1'b1;
                    end
                end
                SEQ_SEND: begin
                    if (out_fire && at_last) begin
                        state    <= SEQ_LAST;
                        out_last <= 1'b1;
                    end
                end
                SEQ_LAST: begin
                    if (out_fire) begin
                        state     <= SEQ_IDLE;
                        out_valid <= 1'b0;
                        out_last  <= 1'b0;
                    end
                end
                default: begin
                    state <= SEQ_IDLE;
                end
            endcase
        end
    end

    // Output word, held as long as it is not taken
    always_ff @(posedge clock) begin
        if (load) begin
            out_data <= rd_data;
            out_user <= rd_user;
            out_dest <= DEST_WIDTH'(slot_index);
        end
    end

endmodule

// File: logic/packet_remapper.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Stream packet remapper top level
// PACKET_LENGTH must be at least 2
// Window is DEST_BASE to DEST_BASE + PACKET_LENGTH - 1
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module packet_remapper import remap_pkg::*; #(
    parameter int DATA_WIDTH    = 32,
    parameter int USER_WIDTH    = 8,
    parameter int DEST_WIDTH    = 8,
    parameter int PACKET_LENGTH = 3,
    parameter int DEST_BASE     = 0,
    localparam int INDEX_WIDTH  = $clog2(PACKET_LENGTH)
) (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  sync,
    input  logic                  in_valid,
    output logic                  in_ready,
    input  logic [DATA_WIDTH-1:0] in_data,
    input  logic [USER_WIDTH-1:0] in_user,
    input  logic [DEST_WIDTH-1:0] in_dest,
    output logic                  out_valid,
    input  logic                  out_ready,
    output logic [DATA_WIDTH-1:0] out_data,
    output logic [USER_WIDTH-1:0] out_user,
    output logic [DEST_WIDTH-1:0] out_dest,
    output logic                  out_last
);

    logic                   buf_valid;
    logic                   buf_ready;
    logic [DATA_WIDTH-1:0]  buf_data;
    logic [USER_WIDTH-1:0]  buf_user;
    logic [DEST_WIDTH-1:0]  buf_dest;
    logic                   wr_en;
    cnt_cmd_t               cnt_cmd;
    logic [INDEX_WIDTH-1:0] slot_index;
    logic                   at_last;
    logic [DATA_WIDTH-1:0]  rd_data;
    logic [USER_WIDTH-1:0]  rd_user;

    // Every word leaving the buffer is offered to the slot store
    assign wr_en = buf_valid && buf_ready;

    skid_buffer #(
        .DATA_WIDTH(DATA_WIDTH), .USER_WIDTH(USER_WIDTH), .DEST_WIDTH(DEST_WIDTH)
    ) u_skid_buffer (
        .clock(clock), .reset(reset),
        .in_valid(in_valid), .in_ready(in_ready),
        .in_data(in_data), .in_user(in_user), .in_dest(in_dest),
        .buf_valid(buf_valid), .buf_ready(buf_ready),
        .buf_data(buf_data), .buf_user(buf_user), .buf_dest(buf_dest)
    );

    slot_store #(
        .DATA_WIDTH(DATA_WIDTH), .USER_WIDTH(USER_WIDTH), .DEST_WIDTH(DEST_WIDTH),
        .PACKET_LENGTH(PACKET_LENGTH), .DEST_BASE(DEST_BASE)
    ) u_slot_store (
        .clock(clock), .reset(reset), .wr_en(wr_en),
        .wr_data(buf_data), .wr_user(buf_user), .wr_dest(buf_dest),
        .rd_index(slot_index), .rd_data(rd_data), .rd_user(rd_user)
    );

    slot_counter #(
        .PACKET_LENGTH(PACKET_LENGTH)
    ) u_slot_counter (
        .clock(clock), .reset(reset), .cmd(cnt_cmd),
        .slot_index(slot_index), .at_last(at_last)
    );

    frame_sequencer #(
        .DATA_WIDTH(DATA_WIDTH), .USER_WIDTH(USER_WIDTH), .DEST_WIDTH(DEST_WIDTH),
        .PACKET_LENGTH(PACKET_LENGTH)
    ) u_frame_sequencer (
        .clock(clock), .reset(reset), .sync(sync),
        .buf_ready(buf_ready), .cnt_cmd(cnt_cmd),
        .slot_index(slot_index), .at_last(at_last),
        .rd_data(rd_data), .rd_user(rd_user),
        .out_valid(out_valid), .out_ready(out_ready),
        .out_data(out_data), .out_user(out_user),
        .out_dest(out_dest), .out_last(out_last)
    );

endmodule

// File: verif/tb_clock_gen.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Free-running testbench clock
// Starts low, first rising edge after half a period
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module tb_clock_gen #(
    parameter int PERIOD = 10
) (
    output logic clock
);

    initial begin
        clock = 1'b0;
        forever begin
            #(PERIOD / 2) clock = ~clock;
        end
    end

endmodule

// File: verif/packet_remapper_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the packet remapper with default parameters
// Inputs change on the falling edge and checks sample on the rising edge
// Stops at the first failed check
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module packet_remapper_tb import remap_pkg::*; ();

    localparam int DATA_WIDTH    = 32;
    localparam int USER_WIDTH    = 8;
    localparam int DEST_WIDTH    = 8;
    localparam int PACKET_LENGTH = 3;
    localparam int DEST_BASE     = 0;
    localparam int TIMEOUT       = 200;

    logic                  clock;
    logic                  reset;
    logic                  sync;
    logic                  in_valid;
    logic                  in_ready;
    logic [DATA_WIDTH-1:0] in_data;
    logic [USER_WIDTH-1:0] in_user;
    logic [DEST_WIDTH-1:0] in_dest;
    logic                  out_valid;
    logic                  out_ready;
    logic [DATA_WIDTH-1:0] out_data;
    logic [USER_WIDTH-1:0] out_user;
    logic [DEST_WIDTH-1:0] out_dest;
    logic                  out_last;

    // Slot contents as the input words define them, and the copy taken at sync
    logic [DATA_WIDTH-1:0] model_data [PACKET_LENGTH];
    logic [USER_WIDTH-1:0] model_user [PACKET_LENGTH];
    logic [DATA_WIDTH-1:0] exp_data [PACKET_LENGTH];
    logic [USER_WIDTH-1:0] exp_user [PACKET_LENGTH];
    logic                  frame_active;
    logic                  starting;
    int                    exp_index;
    int                    frame_xfers;
    logic [31:0]           rand_state;

    tb_clock_gen #(.PERIOD(10)) clock_gen (.clock(clock));

    packet_remapper uut (
        .clock(clock), .reset(reset), .sync(sync),
        .in_valid(in_valid), .in_ready(in_ready),
        .in_data(in_data), .in_user(in_user), .in_dest(in_dest),
        .out_valid(out_valid), .out_ready(out_ready),
        .out_data(out_data), .out_user(out_user),
        .out_dest(out_dest), .out_last(out_last)
    );

    task automatic stop_run();
        $display("tests failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic report_mismatch(input string msg);
        $display("MISMATCH at time %0t: %s", $time, msg);
        stop_run();
    endtask

    task automatic fail_check(input string msg);
        $display("Error at time %0t: %s", $time, msg);
        stop_run();
    endtask

    function automatic logic [31:0] lcg_step(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic next_random(output logic [31:0] value);
        rand_state = lcg_step(rand_state);
        value      = rand_state;
    endtask

    // Reset clears the output stream, the FSM and the slot counter
    assert property (@(posedge clock) !reset |=> !out_valid && !out_last && !in_ready
                     && uut.u_frame_sequencer.state == SEQ_IDLE && uut.slot_index == '0)
        else report_mismatch("reset did not clear the outputs, the FSM or the counter");

    assert property (@(posedge clock) $rose(reset) |=> in_ready)
        else fail_check("in_ready did not rise after reset was released");

    assert property (@(posedge clock) disable iff (!reset)
                     sync && uut.u_frame_sequencer.state == SEQ_IDLE |=> out_valid && out_dest == '0)
        else report_mismatch("first word of the frame not present one cycle after sync");

    assert property (@(posedge clock) disable iff (!reset)
                     out_valid && !out_ready |=> out_valid && $stable(out_data)
                     && $stable(out_user) && $stable(out_dest) && $stable(out_last))
        else report_mismatch("output word changed while it was stalled");

    assert property (@(posedge clock) disable iff (!reset)
                     out_valid && out_ready && out_last |=> !out_valid)
        else report_mismatch("out_valid still high after the last word of a frame");

    // Scoreboard that keeps the last in-window word per slot
    always @(posedge clock) begin
        if (!reset) begin
            frame_active = 1'b0;
            exp_index    = 0;
            frame_xfers  = 0;
            for (int i = 0; i < PACKET_LENGTH; i++) begin
                model_data[i] = '0;
                model_user[i] = '0;
            end
        end else begin
            // A sync while a frame is in flight starts nothing
            starting = sync && !frame_active;
            if (out_valid && out_ready) begin
                assert (frame_active) else fail_check("output word seen outside a frame");
                assert (out_dest == DEST_WIDTH'(exp_index))
                    else report_mismatch($sformatf("out_dest %0d, expected %0d",
                                         out_dest, exp_index));
                assert (out_data == exp_data[exp_index] && out_user == exp_user[exp_index])
                    else report_mismatch($sformatf("slot %0d gave %h/%h, expected %h/%h",
                                         exp_index, out_data, out_user,
                                         exp_data[exp_index], exp_user[exp_index]));
                assert (out_last == (exp_index == PACKET_LENGTH - 1))
                    else report_mismatch($sformatf("out_last %0b on slot %0d",
                                         out_last, exp_index));
                exp_index++;
                if (exp_index == PACKET_LENGTH) begin
                    frame_active = 1'b0;
                end
            end
            if (starting) begin
                for (int i = 0; i < PACKET_LENGTH; i++) begin
                    exp_data[i] = model_data[i];
                    exp_user[i] = model_user[i];
                end
                frame_active = 1'b1;
                exp_index    = 0;
                frame_xfers  = 0;
            end
            if (in_valid && in_ready) begin
                if (frame_active) begin
                    frame_xfers++;
                    assert (frame_xfers <= 2)
                        else fail_check("more than two words accepted during a frame");
                end
                if (int'(in_dest) >= DEST_BASE && int'(in_dest) < DEST_BASE + PACKET_LENGTH) begin
                    model_data[int'(in_dest) - DEST_BASE] = in_data;
                    model_user[int'(in_dest) - DEST_BASE] = in_user;
                end
            end
        end
    end

    task automatic send_word(input logic [DATA_WIDTH-1:0] data,
                             input logic [USER_WIDTH-1:0] user,
                             input logic [DEST_WIDTH-1:0] dest);
        int waited;
        waited   = 0;
        in_valid = 1'b1;
        in_data  = data;
        in_user  = user;
        in_dest  = dest;
        // in_ready is registered and holds its value until the next rising edge
        while (!in_ready) begin
            @(negedge clock);
            waited++;
            if (waited > TIMEOUT) begin
                fail_check("input word was never accepted");
            end
        end
        @(negedge clock);
        in_valid = 1'b0;
    endtask

    task automatic send_random_word();
        logic [31:0]           r;
        logic [31:0]           d;
        logic [DEST_WIDTH-1:0] dest;
        next_random(r);
        next_random(d);
        // Mostly slots 0 to 3 and now and then anywhere in the destination range
        dest = r[31] ? r[23:16] : DEST_WIDTH'(r[30:29]);
        send_word(d, r[15:8], dest);
    endtask

    task automatic drive_ready(input bit random_ready);
        logic [31:0] r;
        next_random(r);
        out_ready = random_ready ? r[31] : 1'b1;
    endtask

    // Waits for an idle FSM, an empty buffer and an open input so the slots match the model
    task automatic wait_quiet();
        int waited;
        waited = 0;
        while (frame_active || out_valid || uut.buf_valid || !in_ready) begin
            @(negedge clock);
            waited++;
            if (waited > TIMEOUT) begin
                fail_check("design did not return to idle between frames");
            end
        end
    endtask

    task automatic run_frame(input bit random_ready);
        int waited;
        wait_quiet();
        waited = 0;
        sync   = 1'b1;
        drive_ready(random_ready);
        @(negedge clock);
        sync = 1'b0;
        while (frame_active) begin
            drive_ready(random_ready);
            @(negedge clock);
            waited++;
            if (waited > TIMEOUT) begin
                fail_check("frame did not complete");
            end
        end
        out_ready = 1'b1;
    endtask

    // Offers three words to a stalled frame, of which only two fit in the buffer
    task automatic stall_frame();
        logic [DATA_WIDTH-1:0] word_data [3];
        logic [DEST_WIDTH-1:0] word_dest [3];
        logic                  took;
        int                    pushed;
        int                    waited;
        word_data[0] = 32'ha0a0_0001;
        word_data[1] = 32'hb1b1_0002;
        word_data[2] = 32'hc2c2_0003;
        word_dest[0] = DEST_WIDTH'(DEST_BASE);
        word_dest[1] = DEST_WIDTH'(DEST_BASE + 1);
        word_dest[2] = DEST_WIDTH'(DEST_BASE + 1);
        wait_quiet();
        sync      = 1'b1;
        out_ready = 1'b0;
        @(negedge clock);
        pushed = 0;
        for (int cyc = 0; cyc < 8; cyc++) begin
            in_valid = 1'b1;
            in_data  = word_data[pushed];
            in_user  = USER_WIDTH'(8'h50 + pushed);
            in_dest  = word_dest[pushed];
            sync     = (cyc == 4);
            took     = in_ready;
            @(negedge clock);
            if (took) begin
                pushed++;
            end
        end
        sync = 1'b0;
        assert (pushed == 2)
            else report_mismatch($sformatf("%0d words accepted during a stalled frame", pushed));
        // The third word goes in once the frame is over
        out_ready = 1'b1;
        waited    = 0;
        while (!in_ready) begin
            @(negedge clock);
            waited++;
            if (waited > TIMEOUT) begin
                fail_check("input stayed closed after the frame ended");
            end
        end
        @(negedge clock);
        in_valid = 1'b0;
    endtask

    initial begin
        int waited;
        rand_state = 32'he56;
        reset      = 1'b0;
        sync       = 1'b0;
        in_valid   = 1'b0;
        in_data    = '0;
        in_user    = '0;
        in_dest    = '0;
        out_ready  = 1'b1;
        repeat (8) @(negedge clock);
        reset  = 1'b1;
        waited = 0;
        while (!in_ready) begin
            @(negedge clock);
            waited++;
            if (waited > TIMEOUT) begin
                fail_check("in_ready never rose after reset");
            end
        end

        // Nothing written yet, so the first frame is all zero
        run_frame(1'b0);
        for (int s = 0; s < PACKET_LENGTH; s++) begin
            send_word(32'h1000 + s, USER_WIDTH'(s + 1), DEST_WIDTH'(DEST_BASE + s));
        end
        run_frame(1'b0);

        // Words outside the window and a slot written twice
        send_word(32'hdead_0003, 8'he3, DEST_WIDTH'(DEST_BASE + PACKET_LENGTH));
        send_word(32'hdead_00ff, 8'hef, 8'hff);
        send_word(32'h2222_0001, 8'h21, DEST_WIDTH'(DEST_BASE + 1));
        send_word(32'h3333_0001, 8'h31, DEST_WIDTH'(DEST_BASE + 1));
        run_frame(1'b0);

        for (int f = 0; f < 6; f++) begin
            for (int w = 0; w < 4; w++) begin
                send_random_word();
            end
            run_frame(1'b1);
        end

        stall_frame();
        run_frame(1'b0);
        wait_quiet();

        $display("all tests passed");
        $finish;
    end

endmodule

// File: packet_remapper.f
logic/remap_pkg.sv
logic/skid_buffer.sv
logic/slot_store.sv
logic/slot_counter.sv
logic/frame_sequencer.sv
logic/packet_remapper.sv
verif/tb_clock_gen.sv
verif/packet_remapper_tb.sv

// File: Makefile
# Verilator build and run of the packet remapper testbench

VERILATOR       ?= verilator
FILELIST        ?= packet_remapper.f
TOP             ?= packet_remapper_tb
BUILD_DIR       ?= build
LOG             ?= sim.log
VERILATOR_FLAGS ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR FILELIST TOP BUILD_DIR LOG VERILATOR_FLAGS"

test:
	$(VERILATOR) $(VERILATOR_FLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "tests failed" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@if ! grep -q "all tests passed" $(LOG); then echo "Simulation incomplete"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
